// ==== qspinor_pkg.sv ====
package qspinor_pkg;

    localparam int addr_w = 24;
    localparam int bus_w  = 32;

    // lanes used by one phase
    typedef enum logic [1:0] {
        lane_x1 = 2'd0,
        lane_x2 = 2'd1,
        lane_x4 = 2'd2
    } lane_w_e;

    // digits are cmd / addr+dummy / data lanes
    typedef enum logic [2:0] {
        mode_111 = 3'd0,
        mode_112 = 3'd1,
        mode_114 = 3'd2,
        mode_122 = 3'd3,
        mode_144 = 3'd4,
        mode_222 = 3'd5,
        mode_444 = 3'd6
    } read_mode_e;

    typedef enum logic [1:0] {
        acc_1b = 2'd0,
        acc_2b = 2'd1,
        acc_4b = 2'd2
    } acc_e;

    typedef enum logic [1:0] {
        op_tx  = 2'd0,
        op_rx  = 2'd1,
        op_dmy = 2'd2
    } shift_op_e;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        acc_e              acc;
    } bus_req_t;

    typedef struct packed {
        read_mode_e  mode;
        logic [7:0]  cmd_octet;
        logic [3:0]  dmy_cnt;
        logic        dmy_dir;     // 1 drives the pins
        logic [3:0]  dmy_pattern;
    } nor_cfg_t;

    typedef struct packed {
        shift_op_e   op;
        lane_w_e     width;
        logic [7:0]  tx_byte;
        logic        dmy_dir;
        logic [3:0]  dmy_pattern;
    } shift_cmd_t;

    typedef struct packed {
        logic        csb;
        logic        sclk;
        logic [3:0]  dir;         // 1 is output
        logic [3:0]  mosi;
    } qspi_out_t;

endpackage

// ==== qspinor_bus_port.sv ====
module qspinor_bus_port (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  req,
    input  logic                  w_rb,
    input  qspinor_pkg::bus_req_t bus_req,
    input  logic                  busy,
    output logic                  fault,
    output logic                  start,
    output qspinor_pkg::bus_req_t latched
);

    logic invld_wr;
    logic invld_acc;
    logic invld;
    logic in_prog;
    logic accept;

    assign invld_wr  = w_rb;    // read-only port
    assign invld_acc = (bus_req.addr[0] && bus_req.acc != qspinor_pkg::acc_1b) ||
                       (bus_req.addr[1:0] == 2'd2 && bus_req.acc == qspinor_pkg::acc_4b);
    assign invld     = invld_wr | invld_acc;

    // start cycle counts as busy, the sequencer is still idle there
    assign in_prog = busy | start;
    assign fault   = req & ~in_prog & invld;
    assign accept  = req & ~in_prog & ~invld;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            start <= 1'b0;
        end else begin
            start <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            latched <= bus_req;
        end
    end

    a_no_start_busy: assert property (@(posedge clk) disable iff (!rstn)
        start |-> !busy);

endmodule

// ==== qspinor_read_seq.sv ====
module qspinor_read_seq (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              start,
    input  qspinor_pkg::bus_req_t             latched,
    input  qspinor_pkg::nor_cfg_t             cfg,
    input  logic                              shift_done,
    input  logic [7:0]                        rx_byte,
    output logic                              busy,
    output logic                              resp,
    output logic [qspinor_pkg::bus_w-1:0]     rdata,
    output logic                              shift_req,
    output qspinor_pkg::shift_cmd_t           cmd,
    output logic                              csb
);

    typedef enum logic [2:0] {
        s_idle, s_wait, s_prep, s_cmd, s_addr, s_dummy, s_data
    } state_e;

    state_e state, next_state;
    logic [3:0] cnt, next_cnt;     // addr bytes, dummy clocks or data bytes left
    qspinor_pkg::lane_w_e cmd_lane, adr_lane, dat_lane;
    logic [1:0] last_idx;
    logic [1:0] byte_idx;

    always_comb begin
        case (cfg.mode)
            qspinor_pkg::mode_444: begin
                cmd_lane = qspinor_pkg::lane_x4;
                adr_lane = qspinor_pkg::lane_x4;
                dat_lane = qspinor_pkg::lane_x4;
            end
            qspinor_pkg::mode_222: begin
                cmd_lane = qspinor_pkg::lane_x2;
                adr_lane = qspinor_pkg::lane_x2;
                dat_lane = qspinor_pkg::lane_x2;
            end
            qspinor_pkg::mode_144: begin
                cmd_lane = qspinor_pkg::lane_x1;
                adr_lane = qspinor_pkg::lane_x4;
                dat_lane = qspinor_pkg::lane_x4;
            end
            qspinor_pkg::mode_122: begin
                cmd_lane = qspinor_pkg::lane_x1;
                adr_lane = qspinor_pkg::lane_x2;
                dat_lane = qspinor_pkg::lane_x2;
            end
            qspinor_pkg::mode_114: begin
                cmd_lane = qspinor_pkg::lane_x1;
                adr_lane = qspinor_pkg::lane_x1;
                dat_lane = qspinor_pkg::lane_x4;
            end
            qspinor_pkg::mode_112: begin
                cmd_lane = qspinor_pkg::lane_x1;
                adr_lane = qspinor_pkg::lane_x1;
                dat_lane = qspinor_pkg::lane_x2;
            end
            default: begin
                cmd_lane = qspinor_pkg::lane_x1;
                adr_lane = qspinor_pkg::lane_x1;
                dat_lane = qspinor_pkg::lane_x1;
            end
        endcase
    end

    assign last_idx = (latched.acc == qspinor_pkg::acc_4b) ? 2'd3 :
                      (latched.acc == qspinor_pkg::acc_2b) ? 2'd1 : 2'd0;

    // next state, plus the unit handed to the shifter this cycle
    always_comb begin
        next_state      = state;
        next_cnt        = cnt;
        shift_req       = 1'b0;
        cmd.op          = qspinor_pkg::op_tx;
        cmd.width       = cmd_lane;
        cmd.tx_byte     = cfg.cmd_octet;
        cmd.dmy_dir     = cfg.dmy_dir;
        cmd.dmy_pattern = cfg.dmy_pattern;
        case (state)
            s_idle: begin
                if (start) begin
                    next_state = s_wait;
                    next_cnt   = 4'd1;
                end
            end
            s_wait: begin
                if (cnt == 4'd0) begin
                    next_state = s_prep;
                end else begin
                    next_cnt = cnt - 4'd1;
                end
            end
            s_prep: begin
                shift_req  = 1'b1;       // command octet
                next_state = s_cmd;
            end
            default: begin
                if (shift_done) begin
                    if ((state == s_cmd) || (state == s_addr && cnt != 4'd0)) begin
                        next_state  = s_addr;
                        next_cnt    = (state == s_cmd) ? 4'd2 : cnt - 4'd1;
                        shift_req   = 1'b1;
                        cmd.width   = adr_lane;
                        cmd.tx_byte = latched.addr[8*next_cnt[1:0] +: 8];  // high byte first
                    end else if ((state == s_addr && cfg.dmy_cnt != 4'd0) ||
                                 (state == s_dummy && cnt != 4'd1)) begin
                        next_state = s_dummy;
                        next_cnt   = (state == s_addr) ? cfg.dmy_cnt : cnt - 4'd1;
                        shift_req  = 1'b1;
                        cmd.op     = qspinor_pkg::op_dmy;
                        cmd.width  = adr_lane;
                    end else if (state != s_data || cnt != 4'd0) begin
                        next_state = s_data;
                        next_cnt   = (state == s_data) ? cnt - 4'd1 : {2'b00, last_idx};
                        shift_req  = 1'b1;
                        cmd.op     = qspinor_pkg::op_rx;
                        cmd.width  = dat_lane;
                    end else begin
                        next_state = s_idle;    // last data byte in
                        next_cnt   = 4'd0;
                    end
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= s_idle;
            cnt   <= 4'd0;
            resp  <= 1'b0;
            csb   <= 1'b1;
        end else begin
            state <= next_state;
            cnt   <= next_cnt;
            resp  <= (state == s_data) && (next_state == s_idle);
            if (next_state == s_idle) begin
                csb <= 1'b1;
            end else if (state == s_wait) begin
                csb <= 1'b0;
            end
        end
    end

    assign busy     = (state != s_idle);
    assign byte_idx = last_idx - cnt[1:0];    // little endian fill

    always_ff @(posedge clk) begin
        if (start) begin
            rdata <= '0;
        end else if (state == s_data && shift_done) begin
            rdata[8*byte_idx +: 8] <= rx_byte;
        end
    end

    a_req_cs_low: assert property (@(posedge clk) disable iff (!rstn)
        shift_req |-> !csb);
    a_resp_pulse: assert property (@(posedge clk) disable iff (!rstn)
        resp |=> !resp);

endmodule

// ==== qspinor_shifter.sv ====
module qspinor_shifter #(
    parameter bit sclk_idle_high = 1'b0
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      shift_req,
    input  qspinor_pkg::shift_cmd_t   cmd,
    input  logic                      csb,
    input  logic [3:0]                miso,
    output logic                      shift_done,
    output logic [7:0]                rx_byte,
    output qspinor_pkg::qspi_out_t    qspi
);

    typedef enum logic [1:0] {
        st_idle, st_tx, st_rx, st_dmy
    } state_e;

    state_e state;
    logic [3:0] cnt;               // odd is low phase, even is high phase
    logic [3:0] load_cnt;
    logic unit_end;
    qspinor_pkg::shift_cmd_t unit; // held for the whole unit
    logic [6:0] rx_sh;

    assign unit_end = (state == st_idle) || (cnt == 4'd0);

    always_comb begin
        case (cmd.width)
            qspinor_pkg::lane_x1: load_cnt = 4'd15;
            qspinor_pkg::lane_x2: load_cnt = 4'd7;
            default:              load_cnt = 4'd3;
        endcase
        if (cmd.op == qspinor_pkg::op_dmy) begin
            load_cnt = 4'd1;       // one clock
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state      <= st_idle;
            cnt        <= 4'd0;
            shift_done <= 1'b0;
        end else begin
            shift_done <= (state != st_idle) && (cnt == 4'd1);
            if (!unit_end) begin
                cnt <= cnt - 4'd1;
            end else if (shift_req) begin
                cnt <= load_cnt;
                case (cmd.op)
                    qspinor_pkg::op_tx: state <= st_tx;
                    qspinor_pkg::op_rx: state <= st_rx;
                    default:            state <= st_dmy;
                endcase
            end else begin
                state <= st_idle;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (shift_req && unit_end) begin
            unit <= cmd;
        end
    end

    // earlier groups, taken in the high phase
    always_ff @(posedge clk) begin
        if (state == st_rx && !cnt[0]) begin
            case (unit.width)
                qspinor_pkg::lane_x1: rx_sh <= {rx_sh[5:0], miso[1]};
                qspinor_pkg::lane_x2: rx_sh <= {rx_sh[4:0], miso[1:0]};
                default:              rx_sh <= {rx_sh[2:0], miso};
            endcase
        end
    end

    // last group comes straight off the pins in the shift_done cycle
    always_comb begin
        case (unit.width)
            qspinor_pkg::lane_x1: rx_byte = {rx_sh[6:0], miso[1]};
            qspinor_pkg::lane_x2: rx_byte = {rx_sh[5:0], miso[1:0]};
            default:              rx_byte = {rx_sh[3:0], miso};
        endcase
    end

    always_comb begin
        qspi.csb  = csb;
        qspi.sclk = (state == st_idle) ? sclk_idle_high : ~cnt[0];
        qspi.dir  = 4'b0000;
        qspi.mosi = 4'b0000;
        case (state)
            st_tx: begin
                case (unit.width)
                    qspinor_pkg::lane_x1: begin
                        qspi.dir  = 4'b0001;
                        qspi.mosi = {3'b000, unit.tx_byte[cnt[3:1]]};
                    end
                    qspinor_pkg::lane_x2: begin
                        qspi.dir  = 4'b0011;
                        qspi.mosi = {2'b00, unit.tx_byte[{cnt[2:1], 1'b0} +: 2]};
                    end
                    default: begin
                        qspi.dir  = 4'b1111;
                        qspi.mosi = unit.tx_byte[{cnt[1], 2'b00} +: 4];
                    end
                endcase
            end
            st_dmy: begin
                qspi.mosi = unit.dmy_pattern;
                if (unit.dmy_dir) begin
                    qspi.dir = 4'b1111;
                end
            end
            default: begin
                qspi.dir = 4'b0000;
            end
        endcase
    end

    a_no_mid_unit_req: assert property (@(posedge clk) disable iff (!rstn)
        shift_req |-> unit_end);

endmodule

// ==== qspinor_top.sv ====
module qspinor_top #(
    parameter bit sclk_idle_high = 1'b0
) (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic                           req,
    input  logic                           w_rb,
    input  qspinor_pkg::bus_req_t          bus_req,
    output logic [qspinor_pkg::bus_w-1:0]  rdata,
    output logic                           resp,
    output logic                           fault,
    input  qspinor_pkg::nor_cfg_t          cfg,
    output qspinor_pkg::qspi_out_t         qspi,
    input  logic [3:0]                     miso
);

    logic                    start;
    logic                    busy;
    qspinor_pkg::bus_req_t   latched;
    logic                    shift_req;
    qspinor_pkg::shift_cmd_t cmd;
    logic                    csb;
    logic                    shift_done;
    logic [7:0]              rx_byte;

    qspinor_bus_port i_bus_port (
        .clk     (clk),
        .rstn    (rstn),
        .req     (req),
        .w_rb    (w_rb),
        .bus_req (bus_req),
        .busy    (busy),
        .fault   (fault),
        .start   (start),
        .latched (latched)
    );

    qspinor_read_seq i_read_seq (
        .clk        (clk),
        .rstn       (rstn),
        .start      (start),
        .latched    (latched),
        .cfg        (cfg),
        .shift_done (shift_done),
        .rx_byte    (rx_byte),
        .busy       (busy),
        .resp       (resp),
        .rdata      (rdata),
        .shift_req  (shift_req),
        .cmd        (cmd),
        .csb        (csb)
    );

    qspinor_shifter #(
        .sclk_idle_high (sclk_idle_high)
    ) i_shifter (
        .clk        (clk),
        .rstn       (rstn),
        .shift_req  (shift_req),
        .cmd        (cmd),
        .csb        (csb),
        .miso       (miso),
        .shift_done (shift_done),
        .rx_byte    (rx_byte),
        .qspi       (qspi)
    );

endmodule

// ==== tb_clk_gen.sv ====
module tb_clk_gen #(
    parameter int period = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

endmodule

// ==== tb_flash_model.sv ====
module tb_flash_model (
    input  qspinor_pkg::qspi_out_t  qspi,
    input  qspinor_pkg::nor_cfg_t   cfg,
    output logic [3:0]              miso,
    output logic [7:0]              cmd_seen,
    output logic [23:0]             addr_seen,
    output int                      tail_clks,    // rising edges after the address
    output logic [3:0]              dmy_dir_seen,
    output logic [3:0]              dmy_mosi_seen,
    output logic                    dmy_varied,
    output int                      xfer_cnt
);

    logic       sclk;
    logic       csb;
    int         edges;
    int         cw;
    int         aw;
    int         dw;
    int         g;
    int         per;
    logic [7:0] data;
    logic [3:0] grp;

    assign sclk = qspi.sclk;
    assign csb  = qspi.csb;

    // lane count for one digit of the mode name (0 is the command digit)
    function automatic int lanes(qspinor_pkg::read_mode_e mode, int digit);
        logic [11:0] w;
        case (mode)
            qspinor_pkg::mode_111: w = 12'h111;
            qspinor_pkg::mode_112: w = 12'h112;
            qspinor_pkg::mode_114: w = 12'h114;
            qspinor_pkg::mode_122: w = 12'h122;
            qspinor_pkg::mode_144: w = 12'h144;
            qspinor_pkg::mode_222: w = 12'h222;
            default:               w = 12'h444;
        endcase
        return int'(w[4*(2-digit) +: 4]);
    endfunction

    function automatic logic [3:0] lane_mask(int w);
        return 4'b1111 >> (4 - w);
    endfunction

    always_comb begin
        cw = lanes(cfg.mode, 0);
        aw = lanes(cfg.mode, 1);
        dw = lanes(cfg.mode, 2);
    end

    initial begin
        miso       = 4'h0;
        cmd_seen   = 8'h00;
        addr_seen  = 24'h0;
        tail_clks  = 0;
        dmy_varied = 1'b0;
        xfer_cnt   = 0;
        edges      = 0;
    end

    // sclk rests low between transactions
    always @(posedge sclk or negedge csb) begin
        if (!sclk) begin
            edges         = 0;
            tail_clks     = 0;
            cmd_seen      = 8'h00;
            addr_seen     = 24'h0;
            dmy_dir_seen  = 4'h0;
            dmy_mosi_seen = 4'h0;
            dmy_varied    = 1'b0;
            xfer_cnt++;
        end else if (!csb) begin
            // undriven lanes read as 0
            if (edges < 8 / cw) begin
                cmd_seen = (cmd_seen << cw) | {4'h0, qspi.mosi & qspi.dir & lane_mask(cw)};
            end else if (edges < 8 / cw + 24 / aw) begin
                addr_seen = (addr_seen << aw) | {20'h0, qspi.mosi & qspi.dir & lane_mask(aw)};
            end else begin
                if (tail_clks < int'(cfg.dmy_cnt)) begin
                    if (tail_clks != 0 &&
                        (qspi.dir != dmy_dir_seen || qspi.mosi != dmy_mosi_seen)) begin
                        dmy_varied = 1'b1;
                    end
                    dmy_dir_seen  = qspi.dir;
                    dmy_mosi_seen = qspi.mosi;
                end
                tail_clks++;
            end
            edges++;
        end
    end

    // next data group goes out on the falling edge MSB first
    always @(negedge sclk) begin
        if (!csb) begin
            g = edges - (8 / cw + 24 / aw + int'(cfg.dmy_cnt));
            if (g >= 0) begin
                per  = 8 / dw;
                data = (addr_seen[7:0] + 8'(g / per)) ^ 8'h5a;
                grp  = 4'(data >> (8 - dw * (g % per + 1))) & lane_mask(dw);
                miso = (dw == 1) ? {2'b00, grp[0], 1'b0} : grp;   // x1 data on io1
            end
        end
    end

endmodule

// ==== tb_qspinor.sv ====
module tb_qspinor;

    localparam int clk_period = 40;
    localparam int num_rows   = 19;
    localparam int resp_limit = 300;

    typedef struct packed {
        qspinor_pkg::nor_cfg_t             cfg;
        logic                              w_rb;
        logic [qspinor_pkg::addr_w-1:0]    addr;
        qspinor_pkg::acc_e                 acc;
        logic                              expect_fault;
        logic [qspinor_pkg::bus_w-1:0]     exp_rdata;
    } row_t;

    logic                           clk;
    logic                           rstn;
    logic                           req;
    logic                           w_rb;
    qspinor_pkg::bus_req_t          bus_req;
    logic [qspinor_pkg::bus_w-1:0]  rdata;
    logic                           resp;
    logic                           fault;
    qspinor_pkg::nor_cfg_t          cfg;
    qspinor_pkg::qspi_out_t         qspi;
    logic [3:0]                     miso;

    logic [7:0]   flash_cmd;
    logic [23:0]  flash_addr;
    int           flash_tail;
    logic [3:0]   flash_dmy_dir;
    logic [3:0]   flash_dmy_mosi;
    logic         flash_dmy_varied;
    int           flash_xfers;

    row_t         rows[num_rows];
    string        names[num_rows];
    int           n_added;
    int           err_cnt;
    int           failed_tests;
    logic [31:0]  rnd;

    tb_clk_gen #(.period(clk_period)) i_clk_gen (.clk(clk));

    qspinor_top #(
        .sclk_idle_high (1'b0)
    ) i_dut (
        .clk     (clk),
        .rstn    (rstn),
        .req     (req),
        .w_rb    (w_rb),
        .bus_req (bus_req),
        .rdata   (rdata),
        .resp    (resp),
        .fault   (fault),
        .cfg     (cfg),
        .qspi    (qspi),
        .miso    (miso)
    );

    tb_flash_model i_flash (
        .qspi          (qspi),
        .cfg           (cfg),
        .miso          (miso),
        .cmd_seen      (flash_cmd),
        .addr_seen     (flash_addr),
        .tail_clks     (flash_tail),
        .dmy_dir_seen  (flash_dmy_dir),
        .dmy_mosi_seen (flash_dmy_mosi),
        .dmy_varied    (flash_dmy_varied),
        .xfer_cnt      (flash_xfers)
    );

    function automatic int lanes(qspinor_pkg::read_mode_e mode, int digit);
        logic [11:0] w;
        case (mode)
            qspinor_pkg::mode_111: w = 12'h111;
            qspinor_pkg::mode_112: w = 12'h112;
            qspinor_pkg::mode_114: w = 12'h114;
            qspinor_pkg::mode_122: w = 12'h122;
            qspinor_pkg::mode_144: w = 12'h144;
            qspinor_pkg::mode_222: w = 12'h222;
            default:               w = 12'h444;
        endcase
        return int'(w[4*(2-digit) +: 4]);
    endfunction

    function automatic int byte_count(qspinor_pkg::acc_e acc);
        return (acc == qspinor_pkg::acc_4b) ? 4 : (acc == qspinor_pkg::acc_2b) ? 2 : 1;
    endfunction

    // byte i holds the data at addr + i
    function automatic logic [31:0] expected_rdata(logic [23:0] addr, qspinor_pkg::acc_e acc);
        logic [31:0] d;
        d = '0;
        for (int i = 0; i < byte_count(acc); i++) begin
            d[8*i +: 8] = (addr[7:0] + 8'(i)) ^ 8'h5a;
        end
        return d;
    endfunction

    task automatic report_failure(input string name, input string what);
        err_cnt++;
        $display("%0s: %0s", name, what);
    endtask

    task automatic check_rdata(input string name, input logic [qspinor_pkg::bus_w-1:0] exp,
                               input logic [qspinor_pkg::bus_w-1:0] act);
        if (act !== exp) begin
            err_cnt++;
            $display("Mismatch in %0s: rdata expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_fault(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            err_cnt++;
            $display("Mismatch in %0s: fault expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_flash(input string name, input logic [7:0] exp_cmd,
                               input logic [23:0] exp_addr, input int exp_dmy,
                               input logic [7:0] act_cmd, input logic [23:0] act_addr,
                               input int act_dmy);
        if (act_cmd !== exp_cmd) begin
            err_cnt++;
            $display("Mismatch in %0s: command expected %h, actual %h", name, exp_cmd, act_cmd);
        end
        if (act_addr !== exp_addr) begin
            err_cnt++;
            $display("Mismatch in %0s: address expected %h, actual %h", name, exp_addr, act_addr);
        end
        if (act_dmy != exp_dmy) begin
            err_cnt++;
            $display("Mismatch in %0s: dummy clocks expected %0d, actual %0d",
                     name, exp_dmy, act_dmy);
        end
    endtask

    task automatic check_lanes(input string name, input string what, input logic [3:0] exp,
                               input logic [3:0] act);
        if (act !== exp) begin
            err_cnt++;
            $display("Mismatch in %0s: %0s expected %b, actual %b", name, what, exp, act);
        end
    endtask

    task automatic add_row(input string name, input qspinor_pkg::read_mode_e mode,
                           input logic [7:0] op, input logic [3:0] dmy, input logic ddir,
                           input logic [3:0] pat, input logic wr, input logic [23:0] addr,
                           input qspinor_pkg::acc_e acc, input logic flt);
        row_t r;
        r.cfg.mode        = mode;
        r.cfg.cmd_octet   = op;
        r.cfg.dmy_cnt     = dmy;
        r.cfg.dmy_dir     = ddir;
        r.cfg.dmy_pattern = pat;
        r.w_rb            = wr;
        r.addr            = addr;
        r.acc             = acc;
        r.expect_fault    = flt;
        r.exp_rdata       = flt ? '0 : expected_rdata(addr, acc);
        rows[n_added]     = r;
        names[n_added]    = name;
        n_added++;
    endtask

    task automatic build_table();
        add_row("one_byte_111", qspinor_pkg::mode_111, 8'h03, 4'd0, 1'b0, 4'h0, 1'b0,
                24'h12_3457, qspinor_pkg::acc_1b, 1'b0);
        add_row("one_byte_112", qspinor_pkg::mode_112, 8'h3b, 4'd8, 1'b0, 4'h0, 1'b0,
                24'h00_00ff, qspinor_pkg::acc_1b, 1'b0);
        add_row("one_byte_114", qspinor_pkg::mode_114, 8'h6b, 4'd8, 1'b1, 4'ha, 1'b0,
                24'hab_cd01, qspinor_pkg::acc_1b, 1'b0);
        add_row("one_byte_122", qspinor_pkg::mode_122, 8'hbb, 4'd4, 1'b1, 4'h5, 1'b0,
                24'h80_0010, qspinor_pkg::acc_1b, 1'b0);
        add_row("one_byte_144", qspinor_pkg::mode_144, 8'heb, 4'd6, 1'b1, 4'hf, 1'b0,
                24'hff_fffe, qspinor_pkg::acc_1b, 1'b0);
        add_row("one_byte_222", qspinor_pkg::mode_222, 8'hbb, 4'd2, 1'b0, 4'h0, 1'b0,
                24'h01_0203, qspinor_pkg::acc_1b, 1'b0);
        add_row("one_byte_444", qspinor_pkg::mode_444, 8'heb, 4'd10, 1'b1, 4'h3, 1'b0,
                24'h5a_5a5a, qspinor_pkg::acc_1b, 1'b0);
        add_row("two_byte_114", qspinor_pkg::mode_114, 8'h6b, 4'd8, 1'b0, 4'h0, 1'b0,
                24'h34_5678, qspinor_pkg::acc_2b, 1'b0);
        add_row("two_byte_off2_222", qspinor_pkg::mode_222, 8'hbb, 4'd4, 1'b0, 4'h0, 1'b0,
                24'h00_0102, qspinor_pkg::acc_2b, 1'b0);
        add_row("four_byte_111", qspinor_pkg::mode_111, 8'h0b, 4'd8, 1'b1, 4'h0, 1'b0,
                24'h7f_fffc, qspinor_pkg::acc_4b, 1'b0);
        add_row("four_byte_144", qspinor_pkg::mode_144, 8'heb, 4'd6, 1'b0, 4'h0, 1'b0,
                24'hc0_ffe0, qspinor_pkg::acc_4b, 1'b0);
        add_row("four_byte_444_no_dummy", qspinor_pkg::mode_444, 8'heb, 4'd0, 1'b0, 4'h0,
                1'b0, 24'h10_2030, qspinor_pkg::acc_4b, 1'b0);
        add_row("write_fault", qspinor_pkg::mode_111, 8'h03, 4'd0, 1'b0, 4'h0, 1'b1,
                24'h00_1000, qspinor_pkg::acc_4b, 1'b1);
        add_row("odd_two_byte_fault", qspinor_pkg::mode_111, 8'h03, 4'd0, 1'b0, 4'h0, 1'b0,
                24'h00_1001, qspinor_pkg::acc_2b, 1'b1);
        add_row("four_byte_off2_fault", qspinor_pkg::mode_111, 8'h03, 4'd0, 1'b0, 4'h0, 1'b0,
                24'h00_1002, qspinor_pkg::acc_4b, 1'b1);
        rnd = $urandom;
        add_row("random_112", qspinor_pkg::mode_112, 8'h3b, 4'd8, 1'b0, 4'h0, 1'b0,
                {rnd[23:2], 2'b00}, qspinor_pkg::acc_4b, 1'b0);
        rnd = $urandom;
        add_row("random_122", qspinor_pkg::mode_122, 8'hbb, 4'd4, 1'b1, 4'h9, 1'b0,
                {rnd[23:1], 1'b0}, qspinor_pkg::acc_2b, 1'b0);
        rnd = $urandom;
        add_row("random_444", qspinor_pkg::mode_444, 8'heb, 4'd6, 1'b0, 4'h0, 1'b0,
                {rnd[23:2], 2'b00}, qspinor_pkg::acc_4b, 1'b0);
        rnd = $urandom;
        add_row("random_111", qspinor_pkg::mode_111, 8'h0b, 4'd8, 1'b0, 4'h0, 1'b0,
                {rnd[23:2], 2'b00}, qspinor_pkg::acc_4b, 1'b0);
    endtask

    task automatic run_row(input int i);
        row_t r;
        int   errs_before;
        int   xfers_before;
        int   waited;
        int   dmy_seen;
        logic saw_resp;
        logic saw_csb_low;
        r            = rows[i];
        errs_before  = err_cnt;
        xfers_before = flash_xfers;
        saw_resp     = 1'b0;
        saw_csb_low  = 1'b0;
        @(posedge clk);
        #5;
        cfg          = r.cfg;
        w_rb         = r.w_rb;
        bus_req.addr = r.addr;
        bus_req.acc  = r.acc;
        req          = 1'b1;
        @(negedge clk);
        check_fault(names[i], r.expect_fault, fault);   // combinational in the req cycle
        @(posedge clk);
        #5;
        req = 1'b0;
        if (r.expect_fault) begin
            repeat (20) begin
                @(negedge clk);
                saw_resp    = saw_resp | resp;
                saw_csb_low = saw_csb_low | ~qspi.csb;
            end
            if (saw_resp) report_failure(names[i], "resp came for a faulting request");
            if (saw_csb_low) report_failure(names[i], "csb went low for a faulting request");
            if (flash_xfers != xfers_before) begin
                report_failure(names[i], "flash saw a transaction for a faulting request");
            end
        end else begin
            waited = 0;
            while (!resp && waited < resp_limit) begin
                @(negedge clk);
                waited++;
            end
            if (!resp) begin
                report_failure(names[i], $sformatf("no resp within %0d cycles", resp_limit));
            end else begin
                check_rdata(names[i], r.exp_rdata, rdata);
                if (!qspi.csb) report_failure(names[i], "csb still low in the resp cycle");
                dmy_seen = flash_tail - byte_count(r.acc) * 8 / lanes(r.cfg.mode, 2);
                check_flash(names[i], r.cfg.cmd_octet, r.addr, int'(r.cfg.dmy_cnt),
                            flash_cmd, flash_addr, dmy_seen);
                if (r.cfg.dmy_cnt != 4'd0) begin
                    check_lanes(names[i], "dummy dir", r.cfg.dmy_dir ? 4'hf : 4'h0,
                                flash_dmy_dir);
                    if (r.cfg.dmy_dir) begin
                        check_lanes(names[i], "dummy mosi", r.cfg.dmy_pattern, flash_dmy_mosi);
                    end
                    if (flash_dmy_varied) begin
                        report_failure(names[i], "pins changed between dummy clocks");
                    end
                end
                if (flash_xfers != xfers_before + 1) begin
                    report_failure(names[i], "flash did not see exactly one transaction");
                end
            end
        end
        if (err_cnt != errs_before) failed_tests++;
        $display("test %0s: %0s", names[i], (err_cnt == errs_before) ? "ok" : "error");
    endtask

    initial begin
        rstn         = 1'b0;
        req          = 1'b0;
        w_rb         = 1'b0;
        bus_req      = '0;
        cfg          = '0;
        err_cnt      = 0;
        failed_tests = 0;
        n_added      = 0;
        rnd          = $urandom(32'h2e8a_82a3);   // seeds the generator
        build_table();
        repeat (3) @(posedge clk);
        #5;
        rstn = 1'b1;
        @(negedge clk);
        if (qspi.csb !== 1'b1 || qspi.sclk !== 1'b0 || resp !== 1'b0 || qspi.dir !== 4'h0) begin
            report_failure("reset", "pins or resp not idle after reset");
        end
        for (int i = 0; i < num_rows; i++) begin
            run_row(i);
        end
        $display("tests run: %0d, tests with errors: %0d, failed checks: %0d",
                 num_rows, failed_tests, err_cnt);
        if (err_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // 400 cycles per row
    initial begin
        #(num_rows * 400 * clk_period);
        $display("watchdog expired after %0d cycles, tests did not finish", num_rows * 400);
        $display("Testbench failed");
        $finish;
    end

endmodule

// ==== sources.f ====
qspinor_pkg.sv
qspinor_bus_port.sv
qspinor_read_seq.sv
qspinor_shifter.sv
qspinor_top.sv
tb_clk_gen.sv
tb_flash_model.sv
tb_qspinor.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench, output in $(LOG)"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module tb_qspinor -f sources.f -Mdir obj_dir
	./obj_dir/Vtb_qspinor 2>&1 | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
